// ==== comms_params.svh ====
`ifndef COMMS_PARAMS_SVH
`define COMMS_PARAMS_SVH

// clock cycles per serial bit on both link wires
`define COMMS_CLKS_PER_BIT 16

// width of one player-info packet on the wire
`define COMMS_PACKET_BITS 32

// field positions in the packet word, sent MSB first
`define COMMS_ID_MSB 31
`define COMMS_ID_LSB 30

`define COMMS_DIR_MSB 29
`define COMMS_DIR_LSB 28

`define COMMS_X_MSB 27
`define COMMS_X_LSB 19

`define COMMS_Y_MSB 18
`define COMMS_Y_LSB 10

// bits below the state field are zero fill
`define COMMS_STATE_MSB 9
`define COMMS_STATE_LSB 6

`endif

// ==== game_pkg.sv ====
`default_nettype none

`include "comms_params.svh"

// game-world view of a player, shared by the table, the broadcaster and the top
package game_pkg;

    // player number as carried in the packet
    typedef logic [`COMMS_ID_MSB-`COMMS_ID_LSB:0] player_num_t;

    // number 0 is this station's own player; 1 to 3 are players 2 to 4
    localparam player_num_t MAIN_PLAYER = '0;

    // facing direction
    typedef logic [`COMMS_DIR_MSB-`COMMS_DIR_LSB:0] direction_t;

    // screen coordinate, x and y fields have the same width
    typedef logic [`COMMS_X_MSB-`COMMS_X_LSB:0] coord_t;

    // player state code
    typedef logic [`COMMS_STATE_MSB-`COMMS_STATE_LSB:0] player_state_t;

endpackage

`default_nettype wire

// ==== link_pkg.sv ====
`default_nettype none

`include "comms_params.svh"

// serial link view, packet word and framing phases
package link_pkg;

    typedef logic [`COMMS_PACKET_BITS-1:0] packet_word_t;

    // receiver phases: wait for edge, confirm start, shift data, check stop
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_phase_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_phase_t;

endpackage

`default_nettype wire

// ==== serial_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "comms_params.svh"

module serial_rx
    import link_pkg::*;
#(
    parameter int CLKS_PER_BIT = `COMMS_CLKS_PER_BIT
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         line_in,
    output packet_word_t rx_word,
    output logic         rx_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int IDX_W = $clog2(`COMMS_PACKET_BITS);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(`COMMS_PACKET_BITS - 1);

    logic             line_meta;
    logic             line_sync;
    rx_phase_t        phase;
    logic [CNT_W-1:0] clk_cnt;
    logic [IDX_W-1:0] bit_idx;
    packet_word_t     shift_q;

    // two flop synchronizer, starts at the idle level
    always_ff @(posedge clk) begin
        if (rst) begin
            line_meta <= 1'b1;
            line_sync <= 1'b1;
        end else begin
            line_meta <= line_in;
            line_sync <= line_meta;
        end
    end

    // after the half-bit wait in RX_START every full-bit count ends mid-bit
    always_ff @(posedge clk) begin
        if (rst) begin
            phase    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (phase)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!line_sync) begin
                        phase <= RX_START;
                    end
                end
                RX_START: begin
                    if (clk_cnt == HALF_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // a low pulse gone by mid-bit was only a glitch
                        phase   <= line_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == LAST_BIT) begin
                            phase <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == FULL_BIT) begin
                        // framing error when the stop bit reads low, frame dropped
                        rx_valid <= line_sync;
                        phase    <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: phase <= RX_IDLE;
            endcase
        end
    end

    // data bits arrive MSB first
    always_ff @(posedge clk) begin
        if (phase == RX_DATA && clk_cnt == FULL_BIT) begin
            shift_q <= {shift_q[`COMMS_PACKET_BITS-2:0], line_sync};
        end
    end

    assign rx_word = shift_q;

    // frames are 34 bits apart, so a valid is always a lone pulse
    assert property (@(posedge clk) disable iff (rst) rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

// ==== serial_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "comms_params.svh"

module serial_tx
    import link_pkg::*;
#(
    parameter int CLKS_PER_BIT = `COMMS_CLKS_PER_BIT
) (
    input  logic         clk,
    input  logic         rst,
    input  packet_word_t tx_word,
    input  logic         tx_trigger,
    output logic         tx_busy,
    output logic         line_out
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int IDX_W = $clog2(`COMMS_PACKET_BITS);
    localparam int MSB   = `COMMS_PACKET_BITS - 1;
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [IDX_W-1:0] LAST_BIT = IDX_W'(`COMMS_PACKET_BITS - 1);

    tx_phase_t        phase;
    logic [CNT_W-1:0] clk_cnt;
    logic [IDX_W-1:0] bit_idx;
    packet_word_t     shift_q;

    // line_out is registered, each level holds for one full bit period
    always_ff @(posedge clk) begin
        if (rst) begin
            phase    <= TX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            tx_busy  <= 1'b0;
            line_out <= 1'b1;
        end else begin
            case (phase)
                TX_IDLE: begin
                    clk_cnt <= '0;
                    if (tx_trigger) begin
                        phase    <= TX_START;
                        tx_busy  <= 1'b1;
                        line_out <= 1'b0;
                    end
                end
                TX_START: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt  <= '0;
                        bit_idx  <= '0;
                        phase    <= TX_DATA;
                        line_out <= shift_q[MSB];
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (clk_cnt == FULL_BIT) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == LAST_BIT) begin
                            phase    <= TX_STOP;
                            line_out <= 1'b1;
                        end else begin
                            // shift_q moves on at this same edge
                            line_out <= shift_q[MSB-1];
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                TX_STOP: begin
                    if (clk_cnt == FULL_BIT) begin
                        phase   <= TX_IDLE;
                        tx_busy <= 1'b0;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: phase <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == TX_IDLE && tx_trigger) begin
            shift_q <= tx_word;
        end else if (phase == TX_DATA && clk_cnt == FULL_BIT) begin
            shift_q <= {shift_q[MSB-1:0], 1'b0};
        end
    end

    // the broadcaster must hold its trigger back until the frame is done
    assert property (@(posedge clk) disable iff (rst) tx_trigger |-> !tx_busy);

endmodule

`default_nettype wire

// ==== player_table.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "comms_params.svh"

module player_table
    import game_pkg::*;
    import link_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  packet_word_t  rx_word,
    input  logic          rx_valid,
    input  direction_t    local_direction,
    input  coord_t        local_loc_x,
    input  coord_t        local_loc_y,
    input  player_state_t local_state,
    output direction_t    player1_direction,
    output direction_t    player2_direction,
    output direction_t    player3_direction,
    output direction_t    player4_direction,
    output coord_t        player1_loc_x,
    output coord_t        player2_loc_x,
    output coord_t        player3_loc_x,
    output coord_t        player4_loc_x,
    output coord_t        player1_loc_y,
    output coord_t        player2_loc_y,
    output coord_t        player3_loc_y,
    output coord_t        player4_loc_y,
    output player_state_t player1_state,
    output player_state_t player2_state,
    output player_state_t player3_state,
    output player_state_t player4_state
);

    player_num_t   rx_id;
    direction_t    rx_direction;
    coord_t        rx_loc_x;
    coord_t        rx_loc_y;
    player_state_t rx_state;

    // remote slots indexed by packet player number, 1 to 3 hold players 2 to 4
    direction_t    slot_direction [1:3];
    coord_t        slot_loc_x     [1:3];
    coord_t        slot_loc_y     [1:3];
    player_state_t slot_state     [1:3];

    assign rx_id        = rx_word[`COMMS_ID_MSB:`COMMS_ID_LSB];
    assign rx_direction = rx_word[`COMMS_DIR_MSB:`COMMS_DIR_LSB];
    assign rx_loc_x     = rx_word[`COMMS_X_MSB:`COMMS_X_LSB];
    assign rx_loc_y     = rx_word[`COMMS_Y_MSB:`COMMS_Y_LSB];
    assign rx_state     = rx_word[`COMMS_STATE_MSB:`COMMS_STATE_LSB];

    // a main-station packet coming back to us carries nothing new
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i <= 3; i++) begin
                slot_direction[i] <= '0;
                slot_loc_x[i]     <= '0;
                slot_loc_y[i]     <= '0;
                slot_state[i]     <= '0;
            end
        end else if (rx_valid && rx_id != MAIN_PLAYER) begin
            slot_direction[rx_id] <= rx_direction;
            slot_loc_x[rx_id]     <= rx_loc_x;
            slot_loc_y[rx_id]     <= rx_loc_y;
            slot_state[rx_id]     <= rx_state;
        end
    end

    // local player mirrored one cycle late, in step with the other slots
    always_ff @(posedge clk) begin
        if (rst) begin
            player1_direction <= '0;
            player1_loc_x     <= '0;
            player1_loc_y     <= '0;
            player1_state     <= '0;
        end else begin
            player1_direction <= local_direction;
            player1_loc_x     <= local_loc_x;
            player1_loc_y     <= local_loc_y;
            player1_state     <= local_state;
        end
    end

    assign player2_direction = slot_direction[1];
    assign player3_direction = slot_direction[2];
    assign player4_direction = slot_direction[3];
    assign player2_loc_x     = slot_loc_x[1];
    assign player3_loc_x     = slot_loc_x[2];
    assign player4_loc_x     = slot_loc_x[3];
    assign player2_loc_y     = slot_loc_y[1];
    assign player3_loc_y     = slot_loc_y[2];
    assign player4_loc_y     = slot_loc_y[3];
    assign player2_state     = slot_state[1];
    assign player3_state     = slot_state[2];
    assign player4_state     = slot_state[3];

endmodule

`default_nettype wire

// ==== frame_broadcaster.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "comms_params.svh"

module frame_broadcaster
    import game_pkg::*;
    import link_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          vsync,
    input  direction_t    local_direction,
    input  coord_t        local_loc_x,
    input  coord_t        local_loc_y,
    input  player_state_t local_state,
    input  logic          tx_busy,
    output packet_word_t  tx_word,
    output logic          tx_trigger
);

    logic vsync_q;
    logic vsync_prev;
    logic vsync_rise;
    logic pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            vsync_q    <= 1'b0;
            vsync_prev <= 1'b0;
        end else begin
            vsync_q    <= vsync;
            vsync_prev <= vsync_q;
        end
    end

    assign vsync_rise = vsync_q & ~vsync_prev;

    // a new edge wins over a trigger, so a newer frame stays queued
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (vsync_rise) begin
            pending <= 1'b1;
        end else if (tx_trigger) begin
            pending <= 1'b0;
        end
    end

    // only one packet held, a later edge overwrites it with fresh values
    always_ff @(posedge clk) begin
        if (vsync_rise) begin
            tx_word <= {MAIN_PLAYER, local_direction, local_loc_x, local_loc_y,
                        local_state, {`COMMS_STATE_LSB{1'b0}}};
        end
    end

    assign tx_trigger = pending & ~tx_busy;

    // busy rises right after a trigger, so the trigger cannot repeat
    assert property (@(posedge clk) disable iff (rst) tx_trigger |=> !tx_trigger);

endmodule

`default_nettype wire

// ==== comms.sv ====
`timescale 1ns/10ps
`default_nettype none

module comms
    import game_pkg::*;
    import link_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          vsync,
    input  direction_t    local_direction,
    input  coord_t        local_loc_x,
    input  coord_t        local_loc_y,
    input  player_state_t local_state,
    input  logic          ja_1,
    output logic          ja_0,
    output direction_t    player1_direction,
    output direction_t    player2_direction,
    output direction_t    player3_direction,
    output direction_t    player4_direction,
    output coord_t        player1_loc_x,
    output coord_t        player2_loc_x,
    output coord_t        player3_loc_x,
    output coord_t        player4_loc_x,
    output coord_t        player1_loc_y,
    output coord_t        player2_loc_y,
    output coord_t        player3_loc_y,
    output coord_t        player4_loc_y,
    output player_state_t player1_state,
    output player_state_t player2_state,
    output player_state_t player3_state,
    output player_state_t player4_state
);

    packet_word_t rx_word;
    logic         rx_valid;
    packet_word_t tx_word;
    logic         tx_trigger;
    logic         tx_busy;

    // receive path, ja_1 pin to player slots
    serial_rx u_serial_rx (
        .clk      (clk),
        .rst      (rst),
        .line_in  (ja_1),
        .rx_word  (rx_word),
        .rx_valid (rx_valid)
    );

    player_table u_player_table (
        .clk               (clk),
        .rst               (rst),
        .rx_word           (rx_word),
        .rx_valid          (rx_valid),
        .local_direction   (local_direction),
        .local_loc_x       (local_loc_x),
        .local_loc_y       (local_loc_y),
        .local_state       (local_state),
        .player1_direction (player1_direction),
        .player2_direction (player2_direction),
        .player3_direction (player3_direction),
        .player4_direction (player4_direction),
        .player1_loc_x     (player1_loc_x),
        .player2_loc_x     (player2_loc_x),
        .player3_loc_x     (player3_loc_x),
        .player4_loc_x     (player4_loc_x),
        .player1_loc_y     (player1_loc_y),
        .player2_loc_y     (player2_loc_y),
        .player3_loc_y     (player3_loc_y),
        .player4_loc_y     (player4_loc_y),
        .player1_state     (player1_state),
        .player2_state     (player2_state),
        .player3_state     (player3_state),
        .player4_state     (player4_state)
    );

    // transmit path, one broadcast per frame on ja_0
    frame_broadcaster u_frame_broadcaster (
        .clk             (clk),
        .rst             (rst),
        .vsync           (vsync),
        .local_direction (local_direction),
        .local_loc_x     (local_loc_x),
        .local_loc_y     (local_loc_y),
        .local_state     (local_state),
        .tx_busy         (tx_busy),
        .tx_word         (tx_word),
        .tx_trigger      (tx_trigger)
    );

    serial_tx u_serial_tx (
        .clk        (clk),
        .rst        (rst),
        .tx_word    (tx_word),
        .tx_trigger (tx_trigger),
        .tx_busy    (tx_busy),
        .line_out   (ja_0)
    );

endmodule

`default_nettype wire

// ==== tb_comms.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "comms_params.svh"

module tb_comms
    import game_pkg::*;
    import link_pkg::*;
;

    localparam int CPB = `COMMS_CLKS_PER_BIT;
    // longest wait for a start bit, covers a full frame already on the wire
    localparam int FRAME_TIMEOUT = 40 * CPB;

    logic          clk;
    logic          rst;
    logic          vsync;
    direction_t    local_direction;
    coord_t        local_loc_x;
    coord_t        local_loc_y;
    player_state_t local_state;
    logic          ja_1;
    wire           ja_0;
    direction_t    player1_direction;
    direction_t    player2_direction;
    direction_t    player3_direction;
    direction_t    player4_direction;
    coord_t        player1_loc_x;
    coord_t        player2_loc_x;
    coord_t        player3_loc_x;
    coord_t        player4_loc_x;
    coord_t        player1_loc_y;
    coord_t        player2_loc_y;
    coord_t        player3_loc_y;
    coord_t        player4_loc_y;
    player_state_t player1_state;
    player_state_t player2_state;
    player_state_t player3_state;
    player_state_t player4_state;

    int          errors;
    int          test_start_errors;
    int          tests_passed;
    int          tests_failed;
    logic [31:0] rng_state;

    // expected remote slots, indexed by packet player number
    direction_t    exp_dir [1:3];
    coord_t        exp_x   [1:3];
    coord_t        exp_y   [1:3];
    player_state_t exp_st  [1:3];

    comms uut (
        .clk               (clk),
        .rst               (rst),
        .vsync             (vsync),
        .local_direction   (local_direction),
        .local_loc_x       (local_loc_x),
        .local_loc_y       (local_loc_y),
        .local_state       (local_state),
        .ja_1              (ja_1),
        .ja_0              (ja_0),
        .player1_direction (player1_direction),
        .player2_direction (player2_direction),
        .player3_direction (player3_direction),
        .player4_direction (player4_direction),
        .player1_loc_x     (player1_loc_x),
        .player2_loc_x     (player2_loc_x),
        .player3_loc_x     (player3_loc_x),
        .player4_loc_x     (player4_loc_x),
        .player1_loc_y     (player1_loc_y),
        .player2_loc_y     (player2_loc_y),
        .player3_loc_y     (player3_loc_y),
        .player4_loc_y     (player4_loc_y),
        .player1_state     (player1_state),
        .player2_state     (player2_state),
        .player3_state     (player3_state),
        .player4_state     (player4_state)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // packet layout: id, direction, x, y, state, zero fill
    function automatic packet_word_t make_word(input player_num_t id, input direction_t d,
                                               input coord_t x, input coord_t y,
                                               input player_state_t s);
        packet_word_t w;
        w = '0;
        w[`COMMS_ID_MSB:`COMMS_ID_LSB]       = id;
        w[`COMMS_DIR_MSB:`COMMS_DIR_LSB]     = d;
        w[`COMMS_X_MSB:`COMMS_X_LSB]         = x;
        w[`COMMS_Y_MSB:`COMMS_Y_LSB]         = y;
        w[`COMMS_STATE_MSB:`COMMS_STATE_LSB] = s;
        return w;
    endfunction

    // remote slot outputs packed as {direction, x, y, state}
    function automatic logic [23:0] slot_fields(input int id);
        case (id)
            1: return {player2_direction, player2_loc_x, player2_loc_y, player2_state};
            2: return {player3_direction, player3_loc_x, player3_loc_y, player3_state};
            default: return {player4_direction, player4_loc_x, player4_loc_y, player4_state};
        endcase
    endfunction

    function automatic bit slots_match();
        bit ok;
        ok = 1'b1;
        for (int id = 1; id <= 3; id++) begin
            if (slot_fields(id) !== {exp_dir[id], exp_x[id], exp_y[id], exp_st[id]}) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    task automatic check_direction(input string name, input direction_t exp,
                                   input direction_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_coord(input string name, input coord_t exp, input coord_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_state(input string name, input player_state_t exp,
                               input player_state_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input packet_word_t exp,
                              input packet_word_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_slot(input int id);
        logic [23:0] f;
        f = slot_fields(id);
        check_direction($sformatf("player%0d_direction", id + 1), exp_dir[id], f[23:22]);
        check_coord($sformatf("player%0d_loc_x", id + 1), exp_x[id], f[21:13]);
        check_coord($sformatf("player%0d_loc_y", id + 1), exp_y[id], f[12:4]);
        check_state($sformatf("player%0d_state", id + 1), exp_st[id], f[3:0]);
    endtask

    task automatic check_player1(input direction_t d, input coord_t x, input coord_t y,
                                 input player_state_t s);
        check_direction("player1_direction", d, player1_direction);
        check_coord("player1_loc_x", x, player1_loc_x);
        check_coord("player1_loc_y", y, player1_loc_y);
        check_state("player1_state", s, player1_state);
    endtask

    // inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic set_locals(input direction_t d, input coord_t x, input coord_t y,
                              input player_state_t s);
        local_direction = d;
        local_loc_x     = x;
        local_loc_y     = y;
        local_state     = s;
    endtask

    task automatic pulse_vsync();
        vsync = 1'b1;
        repeat (4) tick();
        vsync = 1'b0;
        repeat (4) tick();
    endtask

    // start bit, 32 data bits MSB first, stop bit
    task automatic send_frame(input packet_word_t word);
        ja_1 = 1'b0;
        repeat (CPB) tick();
        for (int i = `COMMS_PACKET_BITS - 1; i >= 0; i--) begin
            ja_1 = word[i];
            repeat (CPB) tick();
        end
        ja_1 = 1'b1;
        repeat (CPB) tick();
    endtask

    // ja_0 is registered, so it is sampled on falling edges
    task automatic capture_frame(output packet_word_t word, output bit got);
        int waited;
        word   = '0;
        got    = 1'b0;
        waited = 0;
        @(negedge clk);
        while (ja_0 !== 1'b0 && waited < FRAME_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (ja_0 !== 1'b0) begin
            errors++;
            $display("no start bit appeared on ja_0 within %0d cycles", FRAME_TIMEOUT);
        end else begin
            repeat (CPB / 2) @(negedge clk);
            if (ja_0 !== 1'b0) begin
                errors++;
                $display("start bit on ja_0 went high before its midpoint at %0t", $time);
            end
            for (int i = 0; i < `COMMS_PACKET_BITS; i++) begin
                repeat (CPB) @(negedge clk);
                word = {word[`COMMS_PACKET_BITS-2:0], ja_0};
            end
            repeat (CPB) @(negedge clk);
            if (ja_0 !== 1'b1) begin
                errors++;
                $display("stop bit on ja_0 read low at %0t", $time);
            end
            got = 1'b1;
        end
    endtask

    task automatic wait_slots(input int limit);
        int n;
        n = 0;
        while (!slots_match() && n < limit) begin
            tick();
            n++;
        end
        for (int id = 1; id <= 3; id++) begin
            check_slot(id);
        end
    endtask

    task automatic begin_test();
        test_start_errors = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - test_start_errors);
        end
    endtask

    task automatic test_reset();
        bit low_seen;
        begin_test();
        low_seen = 1'b0;
        // local inputs are nonzero, slot 1 has not mirrored them yet
        @(negedge clk);
        check_player1('0, '0, '0, '0);
        for (int i = 0; i < 2 * CPB; i++) begin
            @(negedge clk);
            if (ja_0 !== 1'b1) begin
                low_seen = 1'b1;
            end
        end
        if (low_seen) begin
            errors++;
            $display("ja_0 left the idle level after reset");
        end
        for (int id = 1; id <= 3; id++) begin
            check_slot(id);
        end
        end_test("reset");
    endtask

    task automatic test_local_mirror();
        logic [31:0]   r;
        direction_t    old_d;
        coord_t        old_x;
        coord_t        old_y;
        player_state_t old_s;
        begin_test();
        r     = next_rand();
        old_d = player1_direction;
        old_x = player1_loc_x;
        old_y = player1_loc_y;
        old_s = player1_state;
        tick();
        set_locals(r[1:0], r[10:2], r[19:11], r[23:20]);
        // same cycle, the mirror must not have moved yet
        @(negedge clk);
        check_player1(old_d, old_x, old_y, old_s);
        @(negedge clk);
        check_player1(r[1:0], r[10:2], r[19:11], r[23:20]);
        end_test("local_mirror");
    endtask

    task automatic test_slot_routing();
        logic [31:0] r;
        begin_test();
        tick();
        for (int id = 1; id <= 3; id++) begin
            r = next_rand();
            send_frame(make_word(player_num_t'(id), r[1:0], r[10:2], r[19:11], r[23:20]));
            exp_dir[id] = r[1:0];
            exp_x[id]   = r[10:2];
            exp_y[id]   = r[19:11];
            exp_st[id]  = r[23:20];
            wait_slots(4 * CPB);
        end
        end_test("slot_routing");
    endtask

    task automatic test_main_id_ignored();
        logic [31:0] r;
        begin_test();
        for (int k = 0; k < 2; k++) begin
            r = next_rand();
            send_frame(make_word(MAIN_PLAYER, r[1:0], r[10:2], r[19:11], r[23:20]));
            repeat (4 * CPB) tick();
            for (int id = 1; id <= 3; id++) begin
                check_slot(id);
            end
        end
        end_test("main_id_ignored");
    endtask

    task automatic test_broadcast();
        logic [31:0]  r;
        packet_word_t w;
        bit           got;
        begin_test();
        r = next_rand();
        tick();
        set_locals(r[1:0], r[10:2], r[19:11], r[23:20]);
        repeat (2) tick();
        vsync = 1'b1;
        capture_frame(w, got);
        tick();
        vsync = 1'b0;
        if (got) begin
            check_word("ja_0 frame", make_word(MAIN_PLAYER, r[1:0], r[10:2], r[19:11],
                                               r[23:20]), w);
        end
        repeat (CPB) tick();
        end_test("broadcast");
    endtask

    task automatic test_backpressure_stream();
        logic [31:0]  ra;
        logic [31:0]  rc;
        logic [31:0]  r;
        packet_word_t w1;
        packet_word_t w2;
        bit           g1;
        bit           g2;
        bit           extra;
        player_num_t  id;
        begin_test();
        ra = next_rand();
        rc = next_rand();
        fork
            begin
                capture_frame(w1, g1);
                capture_frame(w2, g2);
            end
            begin
                set_locals(ra[1:0], ra[10:2], ra[19:11], ra[23:20]);
                tick();
                pulse_vsync();
                // two more edges while the first frame is on the wire
                repeat (3 * CPB) tick();
                r = next_rand();
                set_locals(r[1:0], r[10:2], r[19:11], r[23:20]);
                tick();
                pulse_vsync();
                repeat (CPB) tick();
                set_locals(rc[1:0], rc[10:2], rc[19:11], rc[23:20]);
                tick();
                pulse_vsync();
            end
        join
        if (g1) begin
            check_word("ja_0 first frame",
                       make_word(MAIN_PLAYER, ra[1:0], ra[10:2], ra[19:11], ra[23:20]), w1);
        end
        if (g2) begin
            check_word("ja_0 second frame",
                       make_word(MAIN_PLAYER, rc[1:0], rc[10:2], rc[19:11], rc[23:20]), w2);
        end
        extra = 1'b0;
        for (int i = 0; i < 4 * CPB; i++) begin
            @(negedge clk);
            if (ja_0 !== 1'b1) begin
                extra = 1'b1;
            end
        end
        if (extra) begin
            errors++;
            $display("a third frame started on ja_0 after two vsync edges were queued");
        end
        tick();
        for (int k = 0; k < 8; k++) begin
            r  = next_rand();
            id = r[31:30];
            send_frame(make_word(id, r[1:0], r[10:2], r[19:11], r[23:20]));
            if (id != MAIN_PLAYER) begin
                exp_dir[id] = r[1:0];
                exp_x[id]   = r[10:2];
                exp_y[id]   = r[19:11];
                exp_st[id]  = r[23:20];
            end
        end
        wait_slots(4 * CPB);
        end_test("backpressure_stream");
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        vsync        = 1'b0;
        ja_1         = 1'b1;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        rng_state    = 32'h7c82ee38;
        set_locals(2'h2, 9'h15a, 9'h0a7, 4'hc);
        for (int id = 1; id <= 3; id++) begin
            exp_dir[id] = '0;
            exp_x[id]   = '0;
            exp_y[id]   = '0;
            exp_st[id]  = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset();
        test_local_mirror();
        test_slot_routing();
        test_main_id_ignored();
        test_broadcast();
        test_backpressure_stream();

        $display("summary: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
game_pkg.sv
link_pkg.sv
serial_rx.sv
serial_tx.sv
player_table.sv
frame_broadcaster.sv
comms.sv
tb_comms.sv

// ==== Bender.yml ====
package:
  name: comms

sources:
  - include_dirs:
      - .
    files:
      - game_pkg.sv
      - link_pkg.sv
      - serial_rx.sv
      - serial_tx.sv
      - player_table.sv
      - frame_broadcaster.sv
      - comms.sv
      - tb_comms.sv
